//--- all.f
cpu_pkg.sv
instr_queue.sv
control_seq.sv
reg_file.sv
alu_unit.sv
mul_div_unit.sv
result_merge.sv
datapath_top.sv
tb_datapath.sv

//--- tb_datapath.sv
`timescale 1ns/1ns
`default_nettype none

module tb_datapath;

	logic clk;
	logic rst_n;
	logic instr_valid;
	cpu_pkg::word_t instr;
	logic credit_return;
	cpu_pkg::wb_t wb;

	int errors;
	int checks;
	int test_err;
	// credit bookkeeping on the sender side
	int sent;
	int returned;
	int last_wait;
	logic [31:0] rng_state;
	// reference copy of the register file
	cpu_pkg::word_t model_r [16];
	cpu_pkg::word_t model_hi;
	cpu_pkg::word_t model_lo;
	cpu_pkg::wb_t got_q [$];
	cpu_pkg::wb_t exp_q [$];

	datapath_top datapath_top_i (
		.clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr),
		.credit_return(credit_return), .wb(wb)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// global limit on run time
	initial begin
		#1000000;
		$display("simulation ran out of time, stopped by watchdog");
		$display("STATUS: FAIL");
		$finish;
	end

	// sampled mid-cycle where wb and credit_return are settled
	always @(negedge clk) begin
		if (rst_n && wb.valid) begin
			got_q.push_back(wb);
		end
		if (rst_n && credit_return) begin
			returned++;
		end
	end

	// xorshift32
	function cpu_pkg::word_t next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function int credits_left();
		return cpu_pkg::INSTR_QUEUE_DEPTH - (sent - returned);
	endfunction

	function cpu_pkg::word_t read_reg(input cpu_pkg::reg_idx_t r);
		return (r == 4'd0) ? 32'd0 : model_r[r];
	endfunction

	// register operand placed in the rc bits of the c field
	function logic [18:0] reg_c(input cpu_pkg::reg_idx_t r);
		return {r, 15'd0};
	endfunction

	// rotate one bit at a time
	function cpu_pkg::word_t rot_right(input cpu_pkg::word_t v, input int n);
		for (int i = 0; i < n; i++) begin
			v = {v[0], v[31:1]};
		end
		return v;
	endfunction

	function cpu_pkg::word_t rot_left(input cpu_pkg::word_t v, input int n);
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], v[31]};
		end
		return v;
	endfunction

	task check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
		end
	endtask

	// one word on the channel, waits for a credit when none is left
	task send(input cpu_pkg::word_t w, output bit ok);
		last_wait = 0;
		ok = 1'b1;
		while (credits_left() <= 0 && last_wait < 200) begin
			@(posedge clk);
			#1;
			last_wait++;
		end
		if (credits_left() <= 0) begin
			errors++;
			ok = 1'b0;
			$display("no credit came back within 200 cycles, word 0x%08h dropped", w);
		end else begin
			instr_valid = 1'b1;
			instr = w;
			@(posedge clk);
			#1;
			instr_valid = 1'b0;
			sent++;
		end
	endtask

	// builds the word, predicts its result, then sends it
	task issue(input cpu_pkg::opcode_t op, input cpu_pkg::reg_idx_t ra,
		input cpu_pkg::reg_idx_t rb, input logic [18:0] c);
		cpu_pkg::word_t a;
		cpu_pkg::word_t b;
		cpu_pkg::word_t k;
		cpu_pkg::word_t y;
		cpu_pkg::wb_t e;
		logic [63:0] prod;
		longint sa;
		longint sb;
		longint q;
		longint r;
		logic has_wb;
		bit ok;
		a = read_reg(rb);
		b = read_reg(c[18:15]);
		k = {{13{c[18]}}, c};
		has_wb = 1'b1;
		y = '0;
		case (op)
			cpu_pkg::op_ldi, cpu_pkg::op_addi: y = a + k;
			cpu_pkg::op_andi: y = a & k;
			cpu_pkg::op_ori: y = a | k;
			cpu_pkg::op_add: y = a + b;
			cpu_pkg::op_sub: y = a - b;
			cpu_pkg::op_and: y = a & b;
			cpu_pkg::op_or: y = a | b;
			cpu_pkg::op_shr: y = a >> b[4:0];
			cpu_pkg::op_shra: y = $signed(a) >>> b[4:0];
			cpu_pkg::op_shl: y = a << b[4:0];
			cpu_pkg::op_ror: y = rot_right(a, b[4:0]);
			cpu_pkg::op_rol: y = rot_left(a, b[4:0]);
			cpu_pkg::op_neg: y = 32'd0 - b;
			cpu_pkg::op_not: y = ~b;
			cpu_pkg::op_mfhi: y = model_hi;
			cpu_pkg::op_mflo: y = model_lo;
			cpu_pkg::op_mul: begin
				// low 64 bits of the sign-extended product
				prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
				model_hi = prod[63:32];
				model_lo = prod[31:0];
				has_wb = 1'b0;
			end
			cpu_pkg::op_div: begin
				has_wb = 1'b0;
				if (b == 32'd0) begin
					model_lo = '1;
					model_hi = a;
				end else begin
					// truncating divide, remainder follows dividend
					sa = $signed(a);
					sb = $signed(b);
					q = sa / sb;
					r = sa % sb;
					model_lo = q[31:0];
					model_hi = r[31:0];
				end
			end
			default: begin
				has_wb = 1'b0;
				errors++;
				$display("opcode %0d has no reference behavior", op);
			end
		endcase
		send({op, ra, rb, c}, ok);
		if (ok && has_wb) begin
			e.valid = 1'b1;
			e.dest = ra;
			e.data = y;
			exp_q.push_back(e);
			if (ra != 4'd0) begin
				model_r[ra] = y;
			end
		end
	endtask

	// full word via ldi, shl by 16 and ori, r15 is scratch
	task load_word(input cpu_pkg::reg_idx_t r, input cpu_pkg::word_t v);
		issue(cpu_pkg::op_ldi, r, 4'd0, {3'b0, v[31:16]});
		issue(cpu_pkg::op_ldi, 4'd15, 4'd0, 19'd16);
		issue(cpu_pkg::op_shl, r, r, reg_c(4'd15));
		issue(cpu_pkg::op_ori, r, r, {3'b0, v[15:0]});
	endtask

	// compare every writeback seen against the predicted ones, in order
	task drain(input string tag);
		int waited;
		cpu_pkg::wb_t got;
		cpu_pkg::wb_t exp;
		waited = 0;
		while (got_q.size() < exp_q.size() && waited < 3000) begin
			@(posedge clk);
			waited++;
		end
		if (got_q.size() < exp_q.size()) begin
			errors++;
			$display("%s: %0d writebacks never showed up", tag, exp_q.size() - got_q.size());
		end
		while (got_q.size() > 0 && exp_q.size() > 0) begin
			got = got_q.pop_front();
			exp = exp_q.pop_front();
			check("wb.dest", got.dest, exp.dest);
			check("wb.data", got.data, exp.data);
		end
		if (got_q.size() > 0) begin
			errors++;
			$display("%s: %0d writebacks that no instruction asked for", tag, got_q.size());
		end
		got_q.delete();
		exp_q.delete();
		@(posedge clk);
		#1;
	endtask

	task wait_credits_home(input string tag);
		int waited;
		waited = 0;
		while (sent != returned && waited < 200) begin
			@(posedge clk);
			waited++;
		end
		if (sent != returned) begin
			errors++;
			$display("%s: %0d credits still missing after 200 cycles", tag, sent - returned);
		end
		@(posedge clk);
		#1;
	endtask

	task end_test(input string name);
		$display("test %s finished with %0d errors", name, errors - test_err);
		test_err = errors;
	endtask

	task test_reset();
		// quiet outputs with no input
		for (int i = 0; i < 20; i++) begin
			@(negedge clk);
			check("wb.valid", wb.valid, 1'b0);
			check("credit_return", credit_return, 1'b0);
		end
		@(posedge clk);
		#1;
		check("credits_left", credits_left(), cpu_pkg::INSTR_QUEUE_DEPTH);
		issue(cpu_pkg::op_add, 4'd1, 4'd12, reg_c(4'd13));
		drain("reset");
		end_test("reset");
	endtask

	task test_immediates();
		issue(cpu_pkg::op_ldi, 4'd1, 4'd0, 19'h00123);
		issue(cpu_pkg::op_ldi, 4'd2, 4'd0, 19'h7fff0);
		issue(cpu_pkg::op_ldi, 4'd3, 4'd1, 19'h35a5a);
		issue(cpu_pkg::op_ldi, 4'd4, 4'd2, 19'h40001);
		// r0 write still pulses wb, later reads give zero
		issue(cpu_pkg::op_ldi, 4'd0, 4'd0, 19'h00055);
		issue(cpu_pkg::op_add, 4'd5, 4'd0, reg_c(4'd3));
		issue(cpu_pkg::op_add, 4'd6, 4'd0, reg_c(4'd0));
		drain("immediates");
		end_test("immediates");
	endtask

	task test_reg_ops();
		cpu_pkg::word_t r;
		for (int i = 0; i < 4; i++) begin
			load_word(4'd1, next_rand());
			load_word(4'd2, next_rand());
			issue(cpu_pkg::op_add, 4'd3, 4'd1, reg_c(4'd2));
			issue(cpu_pkg::op_sub, 4'd4, 4'd1, reg_c(4'd2));
			issue(cpu_pkg::op_and, 4'd5, 4'd1, reg_c(4'd2));
			issue(cpu_pkg::op_or, 4'd6, 4'd1, reg_c(4'd2));
			issue(cpu_pkg::op_neg, 4'd7, 4'd0, reg_c(4'd2));
			issue(cpu_pkg::op_not, 4'd8, 4'd0, reg_c(4'd1));
			r = next_rand();
			issue(cpu_pkg::op_addi, 4'd9, 4'd1, r[18:0]);
			r = next_rand();
			issue(cpu_pkg::op_andi, 4'd10, 4'd1, r[18:0]);
			r = next_rand();
			issue(cpu_pkg::op_ori, 4'd11, 4'd1, r[18:0]);
			drain("reg_ops");
		end
		end_test("reg_ops");
	endtask

	task test_shifts();
		cpu_pkg::word_t v;
		cpu_pkg::word_t amt;
		for (int i = 0; i < 6; i++) begin
			v = next_rand();
			// odd passes get a negative value for shra
			if (i % 2 == 1) begin
				v[31] = 1'b1;
			end
			amt = (i == 0) ? 32'd0 : (i == 1) ? 32'd1 : (i == 2) ? 32'd31 : next_rand();
			load_word(4'd1, v);
			load_word(4'd2, amt);
			issue(cpu_pkg::op_shr, 4'd3, 4'd1, reg_c(4'd2));
			issue(cpu_pkg::op_shra, 4'd4, 4'd1, reg_c(4'd2));
			issue(cpu_pkg::op_shl, 4'd5, 4'd1, reg_c(4'd2));
			issue(cpu_pkg::op_ror, 4'd6, 4'd1, reg_c(4'd2));
			issue(cpu_pkg::op_rol, 4'd7, 4'd1, reg_c(4'd2));
			drain("shifts");
		end
		end_test("shifts");
	endtask

	task test_mul_div();
		cpu_pkg::word_t a;
		cpu_pkg::word_t b;
		for (int i = 0; i < 4; i++) begin
			a = next_rand();
			b = next_rand();
			if (i == 1) begin
				a = 32'd0 - (a & 32'h0000ffff);
			end
			if (i == 2) begin
				a[31] = 1'b1;
				b[31] = 1'b1;
			end
			load_word(4'd1, a);
			load_word(4'd2, b);
			issue(cpu_pkg::op_mul, 4'd0, 4'd1, reg_c(4'd2));
			issue(cpu_pkg::op_mfhi, 4'd3, 4'd0, 19'd0);
			issue(cpu_pkg::op_mflo, 4'd4, 4'd0, 19'd0);
		end
		for (int i = 0; i < 4; i++) begin
			a = next_rand();
			b = (next_rand() >> 20) | 32'd1;
			if (i % 2 == 1) begin
				b = 32'd0 - b;
			end
			if (i >= 2) begin
				a = 32'd0 - a;
			end
			load_word(4'd1, a);
			load_word(4'd2, b);
			issue(cpu_pkg::op_div, 4'd0, 4'd1, reg_c(4'd2));
			issue(cpu_pkg::op_mfhi, 4'd5, 4'd0, 19'd0);
			issue(cpu_pkg::op_mflo, 4'd6, 4'd0, 19'd0);
		end
		// divisor r0 reads zero
		load_word(4'd1, 32'hfedcba98);
		issue(cpu_pkg::op_div, 4'd0, 4'd1, reg_c(4'd0));
		issue(cpu_pkg::op_mfhi, 4'd7, 4'd0, 19'd0);
		issue(cpu_pkg::op_mflo, 4'd8, 4'd0, 19'd0);
		drain("mul_div");
		end_test("mul_div");
	endtask

	task test_credit_flow();
		load_word(4'd1, next_rand());
		load_word(4'd2, next_rand());
		drain("credit setup");
		// long mul keeps the sequencer busy while the queue fills
		issue(cpu_pkg::op_mul, 4'd0, 4'd1, reg_c(4'd2));
		wait_credits_home("mul pop");
		issue(cpu_pkg::op_ldi, 4'd3, 4'd0, 19'h00abc);
		issue(cpu_pkg::op_add, 4'd4, 4'd3, reg_c(4'd3));
		issue(cpu_pkg::op_sub, 4'd5, 4'd4, reg_c(4'd3));
		issue(cpu_pkg::op_mflo, 4'd6, 4'd0, 19'd0);
		check("credits_left", credits_left(), 0);
		// fifth word has to sit until a credit returns
		issue(cpu_pkg::op_or, 4'd7, 4'd4, reg_c(4'd5));
		check("send_stalled", last_wait > 0, 1'b1);
		drain("credit_flow");
		wait_credits_home("queue drain");
		check("credits_left", credits_left(), cpu_pkg::INSTR_QUEUE_DEPTH);
		end_test("credit_flow");
	endtask

	initial begin
		instr_valid = 1'b0;
		instr = '0;
		rst_n = 1'b0;
		errors = 0;
		checks = 0;
		test_err = 0;
		sent = 0;
		returned = 0;
		last_wait = 0;
		rng_state = 32'd95373;
		model_hi = '0;
		model_lo = '0;
		for (int i = 0; i < 16; i++) begin
			model_r[i] = '0;
		end
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
		test_reset();
		test_immediates();
		test_reg_ops();
		test_shifts();
		test_mul_div();
		test_credit_flow();
		$display("6 tests, %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- datapath_top.sv
`timescale 1ns/1ns
`default_nettype none

module datapath_top (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            instr_valid,
	input  cpu_pkg::word_t  instr,
	output logic            credit_return,
	output cpu_pkg::wb_t    wb
);

	cpu_pkg::instr_t q_head;
	logic q_empty;
	logic q_pop;
	cpu_pkg::opcode_t op;
	cpu_pkg::reg_idx_t ra;
	cpu_pkg::reg_idx_t rb;
	cpu_pkg::reg_idx_t rc;
	logic use_imm;
	cpu_pkg::word_t imm;
	logic z_load;
	logic md_start;
	cpu_pkg::md_op_t md_op;
	logic md_done;
	cpu_pkg::md_result_t md_res;
	cpu_pkg::wb_sel_t wb_sel;
	cpu_pkg::word_t rb_data;
	cpu_pkg::word_t rc_data;
	cpu_pkg::word_t alu_b;
	cpu_pkg::word_t alu_y;
	cpu_pkg::word_t hi;
	cpu_pkg::word_t lo;
	logic hilo_we;
	cpu_pkg::md_result_t hilo_data;

	// constant or rc on the alu b side
	assign alu_b = use_imm ? imm : rc_data;

	instr_queue instr_queue_i (
		.clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr),
		.q_pop(q_pop), .q_head(q_head), .q_empty(q_empty), .credit_return(credit_return)
	);

	control_seq control_seq_i (
		.clk(clk), .rst_n(rst_n), .q_empty(q_empty), .q_head(q_head), .q_pop(q_pop),
		.op(op), .rb(rb), .rc(rc), .ra(ra), .use_imm(use_imm), .imm(imm),
		.z_load(z_load), .md_start(md_start), .md_op(md_op), .md_done(md_done),
		.wb_sel(wb_sel)
	);

	reg_file reg_file_i (
		.clk(clk), .rst_n(rst_n), .rb(rb), .rc(rc), .rb_data(rb_data), .rc_data(rc_data),
		.wb(wb), .hilo_we(hilo_we), .hilo_data(hilo_data), .hi(hi), .lo(lo)
	);

	alu_unit alu_unit_i (.op(op), .a(rb_data), .b(alu_b), .y(alu_y));

	mul_div_unit mul_div_unit_i (
		.clk(clk), .rst_n(rst_n), .start(md_start), .md_op(md_op), .a(rb_data),
		.b(rc_data), .done(md_done), .res(md_res)
	);

	result_merge result_merge_i (
		.clk(clk), .rst_n(rst_n), .alu_y(alu_y), .z_load(z_load), .md_done(md_done),
		.md_res(md_res), .hi(hi), .lo(lo), .wb_sel(wb_sel), .ra(ra), .wb(wb),
		.hilo_we(hilo_we), .hilo_data(hilo_data)
	);

endmodule

`default_nettype wire

//--- result_merge.sv
`timescale 1ns/1ns
`default_nettype none

module result_merge (
	input  logic                  clk,
	input  logic                  rst_n,
	input  cpu_pkg::word_t        alu_y,
	input  logic                  z_load,
	input  logic                  md_done,
	input  cpu_pkg::md_result_t   md_res,
	input  cpu_pkg::word_t        hi,
	input  cpu_pkg::word_t        lo,
	input  cpu_pkg::wb_sel_t      wb_sel,
	input  cpu_pkg::reg_idx_t     ra,
	output cpu_pkg::wb_t          wb,
	output logic                  hilo_we,
	output cpu_pkg::md_result_t   hilo_data
);

	// z register
	cpu_pkg::word_t z_r;

	always_ff @(posedge clk) begin
		if (z_load) begin
			z_r <= alu_y;
		end
		// mul/div result held for the hi/lo write
		if (md_done) begin
			hilo_data <= md_res;
		end
	end

	// hi/lo written the cycle after done
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hilo_we <= 1'b0;
		end else begin
			hilo_we <= md_done;
		end
	end

	// wb_md and wb_none give no register write
	assign wb.valid = (wb_sel == cpu_pkg::wb_z) || (wb_sel == cpu_pkg::wb_hi) ||
		(wb_sel == cpu_pkg::wb_lo);
	assign wb.dest = ra;
	assign wb.data = (wb_sel == cpu_pkg::wb_hi) ? hi :
		(wb_sel == cpu_pkg::wb_lo) ? lo : z_r;

endmodule

`default_nettype wire

//--- mul_div_unit.sv
`timescale 1ns/1ns
`default_nettype none

module mul_div_unit (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  start,
	input  cpu_pkg::md_op_t       md_op,
	input  cpu_pkg::word_t        a,
	input  cpu_pkg::word_t        b,
	output logic                  done,
	output cpu_pkg::md_result_t   res
);

	logic busy;
	cpu_pkg::md_cnt_t cnt;
	cpu_pkg::md_op_t op_r;
	// signs of result, remainder follows dividend
	logic neg_res;
	logic neg_a;
	cpu_pkg::word_t b_mag;
	// product hi/lo, or remainder/quotient
	cpu_pkg::word_t acc_hi;
	cpu_pkg::word_t acc_lo;
	logic [32:0] mul_sum;
	logic [32:0] div_shift;
	logic [32:0] div_sub;
	logic div_fit;
	logic [63:0] prod_mag;

	// shift-and-add step, low bit of acc_lo is the multiplier bit
	assign mul_sum = {1'b0, acc_hi} + (acc_lo[0] ? {1'b0, b_mag} : 33'd0);
	// restoring step
	assign div_shift = {acc_hi, acc_lo[31]};
	assign div_sub = div_shift - {1'b0, b_mag};
	assign div_fit = (div_shift >= {1'b0, b_mag});
	assign prod_mag = {acc_hi, acc_lo};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			cnt <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				cnt <= '0;
			end else if (busy) begin
				if (cnt == cpu_pkg::md_cnt_t'(cpu_pkg::MD_STEPS - 1)) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
				cnt <= cnt + 1'b1;
			end
		end
	end

	// magnitudes loaded on start, one iteration per busy cycle
	always_ff @(posedge clk) begin
		if (start) begin
			op_r <= md_op;
			neg_a <= a[31];
			neg_res <= a[31] ^ b[31];
			b_mag <= b[31] ? -b : b;
			acc_hi <= '0;
			acc_lo <= a[31] ? -a : a;
		end else if (busy) begin
			if (op_r == cpu_pkg::md_mul) begin
				acc_hi <= mul_sum[32:1];
				acc_lo <= {mul_sum[0], acc_lo[31:1]};
			end else begin
				acc_hi <= div_fit ? div_sub[31:0] : div_shift[31:0];
				acc_lo <= {acc_lo[30:0], div_fit};
			end
		end
	end

	// signs applied at the end
	always_comb begin
		if (op_r == cpu_pkg::md_mul) begin
			{res.hi, res.lo} = neg_res ? -prod_mag : prod_mag;
		end else begin
			// divide by zero gives all ones
			res.lo = (b_mag == '0) ? '1 : (neg_res ? -acc_lo : acc_lo);
			res.hi = neg_a ? -acc_hi : acc_hi;
		end
	end

endmodule

`default_nettype wire

//--- alu_unit.sv
`timescale 1ns/1ns
`default_nettype none

module alu_unit (
	input  cpu_pkg::opcode_t  op,
	input  cpu_pkg::word_t    a,
	input  cpu_pkg::word_t    b,
	output cpu_pkg::word_t    y
);

	logic [4:0] shamt;
	logic [63:0] ror_w;
	logic [63:0] rol_w;

	// shift count from low five bits of b
	assign shamt = b[4:0];
	// rotates as shifts of a doubled word
	assign ror_w = {a, a} >> shamt;
	assign rol_w = {a, a} << shamt;

	always_comb begin
		case (op)
			// ldi shares the adder with addi
			cpu_pkg::op_add, cpu_pkg::op_addi, cpu_pkg::op_ldi: begin
				y = a + b;
			end
			cpu_pkg::op_sub: begin
				y = a - b;
			end
			cpu_pkg::op_and, cpu_pkg::op_andi: begin
				y = a & b;
			end
			cpu_pkg::op_or, cpu_pkg::op_ori: begin
				y = a | b;
			end
			cpu_pkg::op_shr: begin
				y = a >> shamt;
			end
			cpu_pkg::op_shra: begin
				y = $signed(a) >>> shamt;
			end
			cpu_pkg::op_shl: begin
				y = a << shamt;
			end
			cpu_pkg::op_ror: begin
				y = ror_w[31:0];
			end
			cpu_pkg::op_rol: begin
				y = rol_w[63:32];
			end
			// unary ops take b
			cpu_pkg::op_neg: begin
				y = -b;
			end
			cpu_pkg::op_not: begin
				y = ~b;
			end
			default: begin
				y = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file (
	input  logic                  clk,
	input  logic                  rst_n,
	input  cpu_pkg::reg_idx_t     rb,
	input  cpu_pkg::reg_idx_t     rc,
	output cpu_pkg::word_t        rb_data,
	output cpu_pkg::word_t        rc_data,
	input  cpu_pkg::wb_t          wb,
	input  logic                  hilo_we,
	input  cpu_pkg::md_result_t   hilo_data,
	output cpu_pkg::word_t        hi,
	output cpu_pkg::word_t        lo
);

	cpu_pkg::word_t regs [16];

	// r0 cleared at reset and never written, so it reads as zero
	assign rb_data = regs[rb];
	assign rc_data = regs[rc];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
			hi <= '0;
			lo <= '0;
		end else begin
			// writes to r0 dropped, pulse still seen on wb
			if (wb.valid && (wb.dest != '0)) begin
				regs[wb.dest] <= wb.data;
			end
			if (hilo_we) begin
				hi <= hilo_data.hi;
				lo <= hilo_data.lo;
			end
		end
	end

endmodule

`default_nettype wire

//--- control_seq.sv
`timescale 1ns/1ns
`default_nettype none

module control_seq (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                q_empty,
	input  cpu_pkg::instr_t     q_head,
	output logic                q_pop,
	output cpu_pkg::opcode_t    op,
	output cpu_pkg::reg_idx_t   rb,
	output cpu_pkg::reg_idx_t   rc,
	output cpu_pkg::reg_idx_t   ra,
	output logic                use_imm,
	output cpu_pkg::word_t      imm,
	output logic                z_load,
	output logic                md_start,
	output cpu_pkg::md_op_t     md_op,
	input  logic                md_done,
	output cpu_pkg::wb_sel_t    wb_sel
);

	cpu_pkg::seq_state_t state;
	cpu_pkg::seq_state_t state_nxt;
	// instruction register
	cpu_pkg::instr_t ir;
	logic is_md;
	logic is_mf;

	// decode from ir
	assign op = ir.opcode;
	assign ra = ir.ra;
	assign rb = ir.rb;
	assign rc = ir.rc;
	// c sign extended, 19 bits
	assign imm = {{13{ir.rc[3]}}, ir.rc, ir.c_lo};

	assign use_imm = (ir.opcode == cpu_pkg::op_ldi) || (ir.opcode == cpu_pkg::op_addi) ||
		(ir.opcode == cpu_pkg::op_andi) || (ir.opcode == cpu_pkg::op_ori);
	assign is_md = (ir.opcode == cpu_pkg::op_mul) || (ir.opcode == cpu_pkg::op_div);
	assign is_mf = (ir.opcode == cpu_pkg::op_mfhi) || (ir.opcode == cpu_pkg::op_mflo);
	assign md_op = (ir.opcode == cpu_pkg::op_div) ? cpu_pkg::md_div : cpu_pkg::md_mul;

	// T-state strobes
	assign q_pop = (state == cpu_pkg::s_fetch);
	assign z_load = (state == cpu_pkg::s_exec) && !is_md && !is_mf;
	assign md_start = (state == cpu_pkg::s_exec) && is_md;

	// writeback source, only in s_write
	always_comb begin
		wb_sel = cpu_pkg::wb_none;
		if (state == cpu_pkg::s_write) begin
			if (is_md) begin
				wb_sel = cpu_pkg::wb_md;
			end else if (ir.opcode == cpu_pkg::op_mfhi) begin
				wb_sel = cpu_pkg::wb_hi;
			end else if (ir.opcode == cpu_pkg::op_mflo) begin
				wb_sel = cpu_pkg::wb_lo;
			end else begin
				wb_sel = cpu_pkg::wb_z;
			end
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			cpu_pkg::s_idle: begin
				if (!q_empty) begin
					state_nxt = cpu_pkg::s_fetch;
				end
			end
			cpu_pkg::s_fetch: begin
				state_nxt = cpu_pkg::s_exec;
			end
			// mul/div go wait on the iterative unit
			cpu_pkg::s_exec: begin
				state_nxt = is_md ? cpu_pkg::s_md_wait : cpu_pkg::s_write;
			end
			cpu_pkg::s_md_wait: begin
				if (md_done) begin
					state_nxt = cpu_pkg::s_write;
				end
			end
			cpu_pkg::s_write: begin
				state_nxt = cpu_pkg::s_idle;
			end
			default: begin
				state_nxt = cpu_pkg::s_idle;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= cpu_pkg::s_idle;
		end else begin
			state <= state_nxt;
		end
	end

	// head word latched on the pop
	always_ff @(posedge clk) begin
		if (q_pop) begin
			ir <= q_head;
		end
	end

endmodule

`default_nettype wire

//--- instr_queue.sv
`timescale 1ns/1ns
`default_nettype none

module instr_queue (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             instr_valid,
	input  cpu_pkg::word_t   instr,
	input  logic             q_pop,
	output cpu_pkg::instr_t  q_head,
	output logic             q_empty,
	output logic             credit_return
);

	// storage, no reset needed
	cpu_pkg::instr_t mem [cpu_pkg::INSTR_QUEUE_DEPTH];
	cpu_pkg::q_ptr_t wr_ptr;
	cpu_pkg::q_ptr_t rd_ptr;
	cpu_pkg::q_cnt_t count;
	logic push;
	logic pop;

	// sender keeps the credit rule, full check is only a guard
	assign push = instr_valid && (count != cpu_pkg::INSTR_QUEUE_DEPTH);
	assign pop = q_pop && !q_empty;
	assign q_empty = (count == '0);
	assign q_head = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= cpu_pkg::instr_t'(instr);
		end
	end

	// pointers wrap at the last slot
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit_return <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == cpu_pkg::q_ptr_t'(cpu_pkg::INSTR_QUEUE_DEPTH - 1)) ?
					'0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == cpu_pkg::q_ptr_t'(cpu_pkg::INSTR_QUEUE_DEPTH - 1)) ?
					'0 : rd_ptr + 1'b1;
			end
			// one credit back per word that left
			credit_return <= pop;
			count <= count + push - pop;
		end
	end

endmodule

`default_nettype wire

//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	// queue sizing, also the sender's credit count after reset
	localparam int INSTR_QUEUE_DEPTH = 4;
	localparam int QUEUE_PTR_W = $clog2(INSTR_QUEUE_DEPTH);
	localparam int QUEUE_CNT_W = $clog2(INSTR_QUEUE_DEPTH + 1);

	// iterations per mul or div
	localparam int MD_STEPS = 32;

	// data and register widths
	typedef logic [31:0] word_t;
	typedef logic [3:0] reg_idx_t;
	typedef logic [QUEUE_PTR_W-1:0] q_ptr_t;
	typedef logic [QUEUE_CNT_W-1:0] q_cnt_t;
	typedef logic [5:0] md_cnt_t;

	// opcode numbering kept from the bus machine, mfhi/mflo added
	typedef enum logic [4:0] {
		op_ldi  = 5'b00001,
		op_add  = 5'b00011,
		op_sub  = 5'b00100,
		op_shr  = 5'b00101,
		op_shra = 5'b00110,
		op_shl  = 5'b00111,
		op_ror  = 5'b01000,
		op_rol  = 5'b01001,
		op_and  = 5'b01010,
		op_or   = 5'b01011,
		op_addi = 5'b01100,
		op_andi = 5'b01101,
		op_ori  = 5'b01110,
		op_mul  = 5'b01111,
		op_div  = 5'b10000,
		op_neg  = 5'b10001,
		op_not  = 5'b10010,
		op_mfhi = 5'b11000,
		op_mflo = 5'b11001
	} opcode_t;

	// instruction word layout, msb first
	// the 19-bit constant c is {rc, c_lo}, so rc and c share bits 18:15
	typedef struct packed {
		opcode_t  opcode;
		reg_idx_t ra;
		reg_idx_t rb;
		reg_idx_t rc;
		logic [14:0] c_lo;
	} instr_t;

	typedef enum logic {
		md_mul,
		md_div
	} md_op_t;

	typedef struct packed {
		word_t hi;
		word_t lo;
	} md_result_t;

	// writeback source picked in s_write
	typedef enum logic [2:0] {
		wb_none,
		wb_z,
		wb_hi,
		wb_lo,
		wb_md
	} wb_sel_t;

	typedef struct packed {
		logic     valid;
		reg_idx_t dest;
		word_t    data;
	} wb_t;

	typedef enum logic [2:0] {
		s_idle,
		s_fetch,
		s_exec,
		s_md_wait,
		s_write
	} seq_state_t;

endpackage

`default_nettype wire
